// ==== all.f ====
+incdir+logic
logic/replay_pkg.sv
logic/replay_ram.sv
logic/replay_ctrl.sv
logic/flush_tags.sv
logic/lane_mux.sv
logic/miss_replay_top.sv
test/tb_miss_replay.sv

// ==== logic/flush_tags.sv ====
/*
  flush tags
  per slot and lane thread and live bits; exceptions kill a thread's slots
*/
`timescale 1ns/1ps
`default_nettype none
`include "replay_params.svh"

module flush_tags (
  input  logic              clk,
  input  logic              rst,
  input  logic              wr_en_i,
  input  replay_pkg::slot_t wr_slot_i,
  input  logic [1:0]        thread_i,
  input  logic              except_i,
  input  logic              except_thread_i,
  input  replay_pkg::slot_t rd_slot_i,
  output logic [1:0]        live_o
);
  import replay_pkg::*;

  logic [`REPLAY_DEPTH-1:0] thr_q [2];
  logic [`REPLAY_DEPTH-1:0] live_q [2];
  logic [`REPLAY_DEPTH-1:0] thr_d [2];
  logic [`REPLAY_DEPTH-1:0] live_d [2];

  // next state applies the capture first and the kill after it
  always_comb begin
    for (int n = 0; n < 2; n++) begin
      thr_d[n]  = thr_q[n];
      live_d[n] = live_q[n];
      if (wr_en_i) begin
        thr_d[n][wr_slot_i]  = thread_i[n];
        live_d[n][wr_slot_i] = 1'b1;
      end
      // slot being written is killed too when its thread matches
      if (except_i)
        live_d[n] = live_d[n] & ~(except_thread_i ? thr_d[n] : ~thr_d[n]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      thr_q[0]  <= '0;
      thr_q[1]  <= '0;
      live_q[0] <= '0;
      live_q[1] <= '0;
      live_o    <= '0;
    end else begin
      thr_q  <= thr_d;
      live_q <= live_d;
      // live bits of the slot on the RAM read port next cycle
      live_o <= {live_d[1][rd_slot_i], live_d[0][rd_slot_i]};
    end
  end

endmodule

`default_nettype wire

// ==== logic/lane_mux.sv ====
/*
  lane replay mux
  re-execute request from the read port, then the replayed op one cycle later
*/
`timescale 1ns/1ps
`default_nettype none

module lane_mux (
  input  logic                    clk,
  input  logic                    rst,
  input  replay_pkg::lane_t       lane_i,
  input  replay_pkg::lane_entry_t entry_i,
  input  logic                    live_i,
  input  logic                    replay_rd_i,
  input  logic                    except_i,
  output replay_pkg::lane_t       lane_o,
  output replay_pkg::ex_req_t     ex_o
);
  import replay_pkg::*;

  mem_op_t op_q;
  logic    ex_en;
  logic    en_q;
  logic    rep_q;

  // dead or non-missing lanes replay disabled
  assign ex_en = replay_rd_i & entry_i.miss & live_i & ~except_i;

  assign ex_o.en   = ex_en;
  assign ex_o.addr = entry_i.op.addr;
  assign ex_o.sz   = entry_i.op.sz;
  assign ex_o.attr = entry_i.op.attr;

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q  <= 1'b0;
      rep_q <= 1'b0;
    end else begin
      en_q  <= ex_en;
      rep_q <= replay_rd_i;
    end
  end

  always_ff @(posedge clk) begin
    if (replay_rd_i)
      op_q <= entry_i.op;
  end

  // replayed op overrides the incoming one
  always_comb begin
    if (rep_q) begin
      lane_o.en = en_q & ~except_i;
      lane_o.op = op_q;
    end else begin
      lane_o = lane_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/miss_replay_top.sv ====
/*
  two-lane miss replay buffer
  captures missing memory ops, asks for skip, then replays them in order
*/
`timescale 1ns/1ps
`default_nettype none

module miss_replay_top (
  input  logic                clk,
  input  logic                rst,
  input  replay_pkg::lane_t   lane_i [2],
  input  logic [1:0]          miss_i,
  input  logic                except_i,
  input  logic                except_thread_i,
  output replay_pkg::lane_t   lane_o [2],
  output replay_pkg::ex_req_t ex_o [2],
  output logic                do_skip_o
);
  import replay_pkg::*;

  logic        wr_en;
  slot_t       wr_slot;
  logic        init_busy;
  logic        rd_advance;
  slot_t       rd_slot;
  logic        replay_rd;
  logic [1:0]  live;
  lane_entry_t wr_entry [2];
  lane_entry_t rd_entry [2];

  assign wr_entry[0] = '{miss: miss_i[0], op: lane_i[0].op};
  assign wr_entry[1] = '{miss: miss_i[1], op: lane_i[1].op};

  replay_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .miss_i       (miss_i),
    .wr_en_o      (wr_en),
    .wr_slot_o    (wr_slot),
    .init_busy_o  (init_busy),
    .rd_advance_o (rd_advance),
    .rd_slot_o    (rd_slot),
    .replay_rd_o  (replay_rd),
    .do_skip_o    (do_skip_o)
  );

  replay_ram u_ram (
    .clk          (clk),
    .rst          (rst),
    .wr_en_i      (wr_en),
    .init_busy_i  (init_busy),
    .wr_slot_i    (wr_slot),
    .wr_data_i    (wr_entry),
    .rd_advance_i (rd_advance),
    .rd_slot_i    (rd_slot),
    .rd_data_o    (rd_entry)
  );

  flush_tags u_tags (
    .clk             (clk),
    .rst             (rst),
    .wr_en_i         (wr_en),
    .wr_slot_i       (wr_slot),
    .thread_i        ({lane_i[1].op.thread, lane_i[0].op.thread}),
    .except_i        (except_i),
    .except_thread_i (except_thread_i),
    .rd_slot_i       (rd_slot),
    .live_o          (live)
  );

  for (genvar n = 0; n < 2; n++) begin : g_lane
    lane_mux u_mux (
      .clk         (clk),
      .rst         (rst),
      .lane_i      (lane_i[n]),
      .entry_i     (rd_entry[n]),
      .live_i      (live[n]),
      .replay_rd_i (replay_rd),
      .except_i    (except_i),
      .lane_o      (lane_o[n]),
      .ex_o        (ex_o[n])
    );
  end

endmodule

`default_nettype wire

// ==== logic/replay_ctrl.sv ====
/*
  replay control
  clear sweep, FIFO pointers, occupancy count, drain delay and skip request
*/
`timescale 1ns/1ps
`default_nettype none
`include "replay_params.svh"

module replay_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic [1:0]        miss_i,
  output logic              wr_en_o,
  output replay_pkg::slot_t wr_slot_o,
  output logic              init_busy_o,
  output logic              rd_advance_o,
  output replay_pkg::slot_t rd_slot_o,
  output logic              replay_rd_o,
  output logic              do_skip_o
);
  import replay_pkg::*;

  typedef logic [`REPLAY_CNT_W-1:0] cnt_t;

  logic                     init_q;
  slot_t                    sweep_q;
  slot_t                    wr_ptr_q;
  slot_t                    rd_ptr_q;
  cnt_t                     cnt_q;
  logic [`DRAIN_CYCLES-1:0] drain_q;
  logic                     skip_q;
  logic                     capture;
  logic                     replay_en;
  logic                     last_out;

  // either lane missing is one capture
  assign capture = (|miss_i) & ~init_q;

  // drain delay elapsed and something is stored
  assign replay_en = drain_q[`DRAIN_CYCLES-1] & (cnt_q != '0);

  // last stored entry leaves with nothing arriving behind it
  assign last_out = replay_en & (cnt_q == cnt_t'(1)) & ~capture;

  assign wr_en_o      = capture;
  assign wr_slot_o    = init_q ? sweep_q : wr_ptr_q;
  assign init_busy_o  = init_q;
  assign rd_advance_o = replay_en;
  assign replay_rd_o  = replay_en;
  assign do_skip_o    = skip_q;

  // next head slot, latched by the RAM on advance
  assign rd_slot_o = replay_en ? rd_ptr_q + 1'b1 : rd_ptr_q;

  // clear sweep after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      init_q  <= 1'b1;
      sweep_q <= '0;
    end else if (init_q) begin
      sweep_q <= sweep_q + 1'b1;
      if (sweep_q == slot_t'(`REPLAY_DEPTH - 1))
        init_q <= 1'b0;
    end
  end

  // FIFO pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (capture)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (replay_en)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({capture, replay_en})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // drain delay and skip request
  always_ff @(posedge clk) begin
    if (rst) begin
      drain_q <= '0;
      skip_q  <= 1'b0;
    end else if (last_out) begin
      drain_q <= '0;
      skip_q  <= 1'b0;
    end else begin
      // skip state keeps the delay line full between captures
      drain_q <= {drain_q[`DRAIN_CYCLES-2:0], capture | skip_q};
      if (capture)
        skip_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/replay_params.svh ====
/*
  miss replay buffer constants
  buffer depth, pointer and count widths, address width and drain delay
*/
`ifndef REPLAY_PARAMS_SVH
`define REPLAY_PARAMS_SVH

// buffer geometry
`define REPLAY_DEPTH 4
`define REPLAY_PTR_W 2
`define REPLAY_CNT_W 3

// memory op geometry
`define VADDR_W 44
`define BANK_CNT 32

// first capture to first replay cycle
`define DRAIN_CYCLES 3

`endif

// ==== logic/replay_pkg.sv ====
/*
  miss replay types
  packed structs for memory ops, lane slots, stored entries and re-execute requests
*/
`default_nettype none
`include "replay_params.svh"

package replay_pkg;

  typedef struct packed {
    logic                  thread;
    logic [`VADDR_W-1:0]   addr;
    logic [4:0]            sz;
    logic [3:0]            attr;
    logic [1:0]            op_type;
    logic [`BANK_CNT-1:0]  banks;
    logic [4:0]            bank0;
    logic                  odd;
    logic [1:0]            addr_low;
    logic                  split;
    logic [8:0]            lsq;
    logic [9:0]            ii;
    logic [5:0]            wq;
    logic                  lsflag;
  } mem_op_t;

  // one lane's issue slot
  typedef struct packed {
    logic    en;
    mem_op_t op;
  } lane_t;

  // one lane's stored slot
  typedef struct packed {
    logic    miss;
    mem_op_t op;
  } lane_entry_t;

  typedef struct packed {
    logic                en;
    logic [`VADDR_W-1:0] addr;
    logic [4:0]          sz;
    logic [3:0]          attr;
  } ex_req_t;

  typedef logic [`REPLAY_PTR_W-1:0] slot_t;

endpackage

`default_nettype wire

// ==== logic/replay_ram.sv ====
/*
  replay entry store
  four entry pairs, registered read address, write-first on the read slot
*/
`timescale 1ns/1ps
`default_nettype none
`include "replay_params.svh"

module replay_ram (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr_en_i,
  input  logic                     init_busy_i,
  input  replay_pkg::slot_t        wr_slot_i,
  input  replay_pkg::lane_entry_t  wr_data_i [2],
  input  logic                     rd_advance_i,
  input  replay_pkg::slot_t        rd_slot_i,
  output replay_pkg::lane_entry_t  rd_data_o [2]
);
  import replay_pkg::*;

  lane_entry_t mem [`REPLAY_DEPTH][2];
  lane_entry_t wr_word [2];
  slot_t       rd_addr_q;
  logic        wr_any;

  // sweep writes all-zero entries, so the miss bit stays clear
  assign wr_any = wr_en_i | init_busy_i;

  always_comb begin
    for (int n = 0; n < 2; n++) begin
      wr_word[n] = init_busy_i ? '0 : wr_data_i[n];
      if (wr_any && wr_slot_i == rd_addr_q)
        rd_data_o[n] = wr_word[n];
      else
        rd_data_o[n] = mem[rd_addr_q][n];
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      rd_addr_q <= '0;
    else if (rd_advance_i)
      rd_addr_q <= rd_slot_i;
  end

  always_ff @(posedge clk) begin
    if (wr_any) begin
      for (int n = 0; n < 2; n++)
        mem[wr_slot_i][n] <= wr_word[n];
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_miss_replay.sv ====
/*
  miss replay buffer testbench
  directed tests for pass-through, single miss, burst, flush and append during replay
*/
`timescale 1ns/1ps
`default_nettype none

module tb_miss_replay;
  import replay_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_TESTS = 5;
  localparam int CYCLES_PER_TEST = 40;

  logic        clk;
  logic        rst;
  lane_t       lane_i [2];
  logic [1:0]  miss_i;
  logic        except_i;
  logic        except_thread_i;
  lane_t       lane_o [2];
  ex_req_t     ex_o [2];
  logic        do_skip_o;

  // expected entries of the current test in capture order
  lane_entry_t exp_ent [16][2];
  logic [1:0]  exp_live [16];
  int          cap_n;
  lane_t       drv_lane [2];
  logic [31:0] lcg_state = 32'h81bebf6c;
  int          errors;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;

  miss_replay_top u_dut (
    .clk             (clk),
    .rst             (rst),
    .lane_i          (lane_i),
    .miss_i          (miss_i),
    .except_i        (except_i),
    .except_thread_i (except_thread_i),
    .lane_o          (lane_o),
    .ex_o            (ex_o),
    .do_skip_o       (do_skip_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // nonzero miss pattern
  function automatic logic [1:0] rand_miss();
    logic [31:0] r;
    r = lcg_next();
    return (r[17:16] == 2'b00) ? 2'b01 : r[17:16];
  endfunction

  task automatic check_lane(input string name, input lane_t got, input lane_t exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_ex(input string name, input ex_req_t got, input ex_req_t exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // each cycle drives on the rising edge and checks at the falling edge
  // rep is the entry expected on the re-execute port and out the one on lane_o
  // a negative index means none expected
  task automatic tick(input logic [1:0] miss, input logic [1:0] thr, input logic exc,
                      input logic exc_th, input int rep, input int out, input logic skip);
    lane_t        nl [2];
    ex_req_t      ee;
    lane_t        el;
    logic [127:0] raw;
    @(posedge clk);
    for (int n = 0; n < 2; n++) begin
      raw = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
      nl[n] = raw[$bits(lane_t)-1:0];
      nl[n].op.thread = thr[n];
      lane_i[n] <= nl[n];
      drv_lane[n] = nl[n];
      if (miss != 2'b00) begin
        exp_ent[cap_n][n] = '{miss: miss[n], op: nl[n].op};
        exp_live[cap_n][n] = 1'b1;
      end
    end
    if (miss != 2'b00)
      cap_n++;
    // an exception kills every stored slot of its thread
    if (exc) begin
      for (int i = 0; i < cap_n; i++)
        for (int n = 0; n < 2; n++)
          if (exp_ent[i][n].op.thread == exc_th)
            exp_live[i][n] = 1'b0;
    end
    miss_i          <= miss;
    except_i        <= exc;
    except_thread_i <= exc_th;
    @(negedge clk);
    for (int n = 0; n < 2; n++) begin
      if (rep >= 0) begin
        ee.en   = exp_ent[rep][n].miss & exp_live[rep][n];
        ee.addr = exp_ent[rep][n].op.addr;
        ee.sz   = exp_ent[rep][n].op.sz;
        ee.attr = exp_ent[rep][n].op.attr;
        check_ex($sformatf("ex_o[%0d]", n), ex_o[n], ee);
      end else begin
        check_bit($sformatf("ex_o[%0d].en", n), ex_o[n].en, 1'b0);
      end
      if (out >= 0) begin
        el.en = exp_ent[out][n].miss & exp_live[out][n];
        el.op = exp_ent[out][n].op;
      end else begin
        el = drv_lane[n];
      end
      check_lane($sformatf("lane_o[%0d]", n), lane_o[n], el);
    end
    check_bit("do_skip_o", do_skip_o, skip);
  endtask

  task automatic begin_test();
    test_errors = 0;
    cap_n = 0;
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d mismatches", name, test_errors);
      tests_failed++;
    end
  endtask

  task automatic test_idle();
    begin_test();
    repeat (8) tick(2'b00, 2'b00, 1'b0, 1'b0, -1, -1, 1'b0);
    end_test("idle pass-through");
  endtask

  task automatic test_single();
    begin_test();
    tick(2'b01, 2'b00, 1'b0, 1'b0, -1, -1, 1'b0);
    tick(2'b00, 2'b00, 1'b0, 1'b0, -1, -1, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, -1, -1, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, 0, -1, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, -1, 0, 1'b0);
    tick(2'b00, 2'b00, 1'b0, 1'b0, -1, -1, 1'b0);
    end_test("single miss");
  endtask

  task automatic test_burst();
    begin_test();
    tick(rand_miss(), 2'b00, 1'b0, 1'b0, -1, -1, 1'b0);
    tick(rand_miss(), 2'b00, 1'b0, 1'b0, -1, -1, 1'b1);
    tick(rand_miss(), 2'b00, 1'b0, 1'b0, -1, -1, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, 0, -1, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, 1, 0, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, 2, 1, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, -1, 2, 1'b0);
    tick(2'b00, 2'b00, 1'b0, 1'b0, -1, -1, 1'b0);
    end_test("burst of three");
  endtask

  task automatic test_flush();
    begin_test();
    tick(2'b11, 2'b00, 1'b0, 1'b0, -1, -1, 1'b0);
    tick(2'b11, 2'b11, 1'b0, 1'b0, -1, -1, 1'b1);
    // exception for thread 1 while lane 0 of a thread-1 op is captured
    tick(2'b11, 2'b01, 1'b1, 1'b1, -1, -1, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, 0, -1, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, 1, 0, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, 2, 1, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, -1, 2, 1'b0);
    tick(2'b00, 2'b00, 1'b0, 1'b0, -1, -1, 1'b0);
    end_test("exception flush");
  endtask

  task automatic test_append();
    begin_test();
    tick(rand_miss(), 2'b00, 1'b0, 1'b0, -1, -1, 1'b0);
    tick(rand_miss(), 2'b00, 1'b0, 1'b0, -1, -1, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, -1, -1, 1'b1);
    // new miss lands in the first replay cycle
    tick(rand_miss(), 2'b00, 1'b0, 1'b0, 0, -1, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, 1, 0, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, 2, 1, 1'b1);
    tick(2'b00, 2'b00, 1'b0, 1'b0, -1, 2, 1'b0);
    tick(2'b00, 2'b00, 1'b0, 1'b0, -1, -1, 1'b0);
    end_test("capture during replay");
  endtask

  // watchdog sized from the test count plus reset and sweep
  initial begin
    #(CLK_PERIOD * (NUM_TESTS * CYCLES_PER_TEST + 8));
    $display("timeout: tests did not finish within the expected number of cycles");
    $display("sim failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    lane_i[0] = '0;
    lane_i[1] = '0;
    miss_i = 2'b00;
    except_i = 1'b0;
    except_thread_i = 1'b0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // clear sweep
    repeat (6) @(posedge clk);
    test_idle();
    test_single();
    test_burst();
    test_flush();
    test_append();
    $display("%0d tests run, %0d passed, %0d failed, %0d mismatches",
             tests_passed + tests_failed, tests_passed, tests_failed, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
